// File: list.f
+incdir+hw
hw/st_pkg.sv
hw/st_bank_map.sv
hw/st_pair_order.sv
hw/st_wport.sv
hw/st_wreq.sv
dv/st_wreq_checker.sv
dv/st_wreq_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= st_wreq_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/st_wreq_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "st_config.svh"

module st_wreq_tb;

  logic clk;
  logic rst;
  logic hold;
  logic s0_en;
  logic [`ST_ADDR_W-1:0] s0_addr;
  st_pkg::st_size_e s0_size;
  logic [`ST_DATA_W-1:0] s0_data;
  logic s1_en;
  logic [`ST_ADDR_W-1:0] s1_addr;
  st_pkg::st_size_e s1_size;
  logic [`ST_DATA_W-1:0] s1_data;
  logic busy;
  logic w0_en, w1_en;
  logic [`ST_ADDR_W-1:0] w0_addr, w1_addr;
  logic [`ST_BANK_W-1:0] w0_bank, w0_end_bank, w1_bank, w1_end_bank;
  logic [`ST_BEN_W-1:0] w0_bgn_ben, w0_end_ben, w1_bgn_ben, w1_end_ben;
  logic [`ST_WDATA_W-1:0] w0_data, w1_data;
  int tb_errors;
  int chk_errors;
  int chk_checks;
  logic chk_drained;

  st_wreq i_st_wreq (.*);

  st_wreq_checker u_chk (
    .clk(clk), .rst(rst), .hold(hold), .busy(busy),
    .s0_en(s0_en), .s0_addr(s0_addr), .s0_size(s0_size), .s0_data(s0_data),
    .s1_en(s1_en), .s1_addr(s1_addr), .s1_size(s1_size), .s1_data(s1_data),
    .w0_en(w0_en), .w0_addr(w0_addr), .w0_bank(w0_bank), .w0_end_bank(w0_end_bank),
    .w0_bgn_ben(w0_bgn_ben), .w0_end_ben(w0_end_ben), .w0_data(w0_data),
    .w1_en(w1_en), .w1_addr(w1_addr), .w1_bank(w1_bank), .w1_end_bank(w1_end_bank),
    .w1_bgn_ben(w1_bgn_ben), .w1_end_ben(w1_end_ben), .w1_data(w1_data),
    .errors(chk_errors), .checks(chk_checks), .drained(chk_drained)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // called right after a falling edge
  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (busy && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      tb_errors++;
      $display("timeout waiting for busy to drop");
    end
  endtask

  task automatic issue_pair(input logic e0, input logic [15:0] a0, input logic [1:0] z0,
                            input logic e1, input logic [15:0] a1, input logic [1:0] z1);
    wait_idle(40);
    s0_en = e0;
    s0_addr = a0;
    s0_size = st_pkg::st_size_e'(z0);
    s0_data = {$urandom, $urandom};
    s1_en = e1;
    s1_addr = a1;
    s1_size = st_pkg::st_size_e'(z1);
    s1_data = {$urandom, $urandom};
    @(negedge clk);
    s0_en = 1'b0;
    s1_en = 1'b0;
  endtask

  // nearby addresses half the time so pairs overlap
  task automatic random_cycle();
    logic [15:0] a0;
    a0 = 16'($urandom);
    if (busy) begin
      s0_en = 1'b0;
      s1_en = 1'b0;
      hold = ($urandom % 4 == 0);
    end else if ($urandom % 8 == 0) begin
      hold = 1'b1;
      s0_en = 1'b0;
      s1_en = 1'b0;
    end else begin
      s0_en = ($urandom % 8 != 0);
      s1_en = ($urandom % 8 != 0);
      s0_addr = a0;
      s1_addr = ($urandom % 2 == 0) ? a0 + 16'($urandom % 17) - 16'd8 : 16'($urandom);
      s0_size = st_pkg::st_size_e'($urandom % 4);
      s1_size = st_pkg::st_size_e'($urandom % 4);
      s0_data = {$urandom, $urandom};
      s1_data = {$urandom, $urandom};
    end
  endtask

  initial begin
    void'($urandom(32'h782));
    tb_errors = 0;
    rst = 1'b1;
    hold = 1'b0;
    s0_en = 1'b0;
    s0_addr = '0;
    s0_size = st_pkg::SZ_BYTE;
    s0_data = '0;
    s1_en = 1'b0;
    s1_addr = '0;
    s1_size = st_pkg::SZ_BYTE;
    s1_data = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // every size at every offset, on each slot
    for (int z = 0; z < 4; z++) begin
      for (int o = 0; o < 4; o++) begin
        issue_pair(1'b1, {14'($urandom), 2'(o)}, 2'(z), 1'b0, 16'h0, 2'd0);
        issue_pair(1'b0, 16'h0, 2'd0, 1'b1, {14'($urandom), 2'(o)}, 2'(z));
      end
    end
    // dwords that wrap past bank 31
    issue_pair(1'b1, 16'h007c, 2'd3, 1'b0, 16'h0, 2'd0);
    issue_pair(1'b1, 16'h117f, 2'd3, 1'b0, 16'h0, 2'd0);
    issue_pair(1'b1, 16'h0100, 2'd2, 1'b1, 16'h0140, 2'd2);
    issue_pair(1'b1, 16'h0200, 2'd1, 1'b1, 16'h0202, 2'd1);
    issue_pair(1'b1, 16'h0300, 2'd3, 1'b1, 16'h0304, 2'd2);
    // overlap, then hold while slot 1 waits
    issue_pair(1'b1, 16'h0400, 2'd2, 1'b1, 16'h0402, 2'd0);
    hold = 1'b1;
    repeat (4) @(negedge clk);
    hold = 1'b0;
    for (int c = 0; c < 1000; c++) begin
      @(negedge clk);
      random_cycle();
    end
    @(negedge clk);
    s0_en = 1'b0;
    s1_en = 1'b0;
    hold = 1'b0;
    wait_idle(40);
    repeat (3) @(negedge clk);
    if (!chk_drained) begin
      tb_errors++;
      $display("stores still expected at end of run");
    end
    $display("checker errors %0d, testbench errors %0d, stores checked %0d",
             chk_errors, tb_errors, chk_checks);
    if (chk_errors == 0 && tb_errors == 0 && chk_checks > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/st_wreq_checker.sv
`default_nettype none
`timescale 1ns/1ps
`include "st_config.svh"

module st_wreq_checker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    hold,
  input  logic                    busy,
  input  logic                    s0_en,
  input  logic [`ST_ADDR_W-1:0]   s0_addr,
  input  logic [1:0]              s0_size,
  input  logic [`ST_DATA_W-1:0]   s0_data,
  input  logic                    s1_en,
  input  logic [`ST_ADDR_W-1:0]   s1_addr,
  input  logic [1:0]              s1_size,
  input  logic [`ST_DATA_W-1:0]   s1_data,
  input  logic                    w0_en,
  input  logic [`ST_ADDR_W-1:0]   w0_addr,
  input  logic [`ST_BANK_W-1:0]   w0_bank,
  input  logic [`ST_BANK_W-1:0]   w0_end_bank,
  input  logic [`ST_BEN_W-1:0]    w0_bgn_ben,
  input  logic [`ST_BEN_W-1:0]    w0_end_ben,
  input  logic [`ST_WDATA_W-1:0]  w0_data,
  input  logic                    w1_en,
  input  logic [`ST_ADDR_W-1:0]   w1_addr,
  input  logic [`ST_BANK_W-1:0]   w1_bank,
  input  logic [`ST_BANK_W-1:0]   w1_end_bank,
  input  logic [`ST_BEN_W-1:0]    w1_bgn_ben,
  input  logic [`ST_BEN_W-1:0]    w1_end_ben,
  input  logic [`ST_WDATA_W-1:0]  w1_data,
  output int                      errors,
  output int                      checks,
  output logic                    drained
);

  localparam int rec_w = `ST_ADDR_W + 2 * `ST_BANK_W + 2 * `ST_BEN_W + `ST_WDATA_W;
  localparam int line_bytes = `ST_BANKS * `ST_BEN_W;

  logic [rec_w-1:0] exp0[$];
  logic [rec_w-1:0] exp1[$];
  logic [rec_w-1:0] defer_rec;
  logic             defer;
  logic             was_rst;

  // expected port record of addr, banks, enables and aligned data
  function automatic logic [rec_w-1:0] ref_store(input logic [`ST_ADDR_W-1:0] addr,
                                                  input logic [1:0] size,
                                                  input logic [`ST_DATA_W-1:0] data);
    int first;
    int last;
    logic [`ST_BEN_W-1:0] bben;
    logic [`ST_BEN_W-1:0] eben;
    logic [`ST_BANK_W-1:0] bb;
    logic [`ST_BANK_W-1:0] eb;
    logic [`ST_WDATA_W-1:0] wide;
    first = int'(addr[`ST_OFF_W+`ST_BANK_W-1:0]);
    last  = first + (1 << size) - 1;
    for (int i = 0; i < `ST_BEN_W; i++) begin
      bben[i] = ((first / 4) * 4 + i >= first) && ((first / 4) * 4 + i <= last);
      eben[i] = ((last / 4) * 4 + i >= first) && ((last / 4) * 4 + i <= last);
    end
    bb = `ST_BANK_W'(first / 4);
    eb = `ST_BANK_W'((last / 4) % `ST_BANKS);
    wide = {32'b0, data} << (8 * addr[1:0]);
    return {addr, bb, eb, bben, eben, wide};
  endfunction

  // line bytes written with wrap at the line end
  function automatic logic [line_bytes-1:0] byte_set(input logic [`ST_ADDR_W-1:0] addr,
                                                     input logic [1:0] size);
    logic [line_bytes-1:0] m;
    int first;
    m = '0;
    first = int'(addr[`ST_OFF_W+`ST_BANK_W-1:0]);
    for (int k = 0; k < (1 << size); k++) m[(first + k) % line_bytes] = 1'b1;
    return m;
  endfunction

  task automatic check_field(input string name, input logic [`ST_WDATA_W-1:0] got,
                             input logic [`ST_WDATA_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s got %0h exp %0h", name, got, exp);
    end
  endtask

  task automatic check_port(input int port, input logic en, input logic [rec_w-1:0] got);
    logic [rec_w-1:0] exp;
    logic found;
    found = 1'b0;
    if (port == 0 && exp0.size() > 0) begin
      exp = exp0.pop_front();
      found = 1'b1;
    end else if (port == 1 && exp1.size() > 0) begin
      exp = exp1.pop_front();
      found = 1'b1;
    end
    if (en && !found) begin
      errors++;
      $display("FAILED w%0d_en got 1 exp 0", port);
    end else if (!en && found) begin
      errors++;
      $display("FAILED w%0d_en got 0 exp 1", port);
    end else if (en) begin
      checks++;
      check_field($sformatf("w%0d_addr", port), 96'(got[rec_w-1 -: 16]), 96'(exp[rec_w-1 -: 16]));
      check_field($sformatf("w%0d_bank", port), 96'(got[113:109]), 96'(exp[113:109]));
      check_field($sformatf("w%0d_end_bank", port), 96'(got[108:104]), 96'(exp[108:104]));
      check_field($sformatf("w%0d_bgn_ben", port), 96'(got[103:100]), 96'(exp[103:100]));
      check_field($sformatf("w%0d_end_ben", port), 96'(got[99:96]), 96'(exp[99:96]));
      check_field($sformatf("w%0d_data", port), got[95:0], exp[95:0]);
    end
  endtask

  initial begin
    errors  = 0;
    checks  = 0;
    defer   = 1'b0;
    was_rst = 1'b0;
    drained = 1'b1;
  end

  // pre-edge values with inputs settled since the falling edge
  always @(posedge clk) begin
    logic conf;
    if (rst) begin
      if (was_rst && w0_en) begin
        errors++;
        $display("FAILED w0_en got %0h exp 0", w0_en);
      end
      if (was_rst && w1_en) begin
        errors++;
        $display("FAILED w1_en got %0h exp 0", w1_en);
      end
      if (was_rst && busy !== hold) begin
        errors++;
        $display("FAILED busy got %0h exp %0h", busy, hold);
      end
      exp0.delete();
      exp1.delete();
      defer = 1'b0;
    end else begin
      if (busy !== (hold || defer)) begin
        errors++;
        $display("FAILED busy got %0h exp %0h", busy, hold || defer);
      end
      check_port(0, w0_en, {w0_addr, w0_bank, w0_end_bank, w0_bgn_ben, w0_end_ben, w0_data});
      check_port(1, w1_en, {w1_addr, w1_bank, w1_end_bank, w1_bgn_ben, w1_end_ben, w1_data});
      if (defer) begin
        if (!hold) begin
          exp1.push_back(defer_rec);
          defer = 1'b0;
        end
      end else if (!hold) begin
        conf = s0_en && s1_en &&
               ((byte_set(s0_addr, s0_size) & byte_set(s1_addr, s1_size)) != '0);
        if (s0_en) exp0.push_back(ref_store(s0_addr, s0_size, s0_data));
        if (conf) begin
          defer_rec = ref_store(s1_addr, s1_size, s1_data);
          defer = 1'b1;
        end else if (s1_en) begin
          exp1.push_back(ref_store(s1_addr, s1_size, s1_data));
        end
      end
    end
    was_rst = rst;
    drained = (exp0.size() == 0) && (exp1.size() == 0) && !defer;
  end

endmodule

`default_nettype wire

// File: hw/st_wreq.sv
`default_nettype none
`timescale 1ns/1ps
`include "st_config.svh"

module st_wreq (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    hold,
  input  logic                    s0_en,
  input  logic [`ST_ADDR_W-1:0]   s0_addr,
  input  st_pkg::st_size_e        s0_size,
  input  logic [`ST_DATA_W-1:0]   s0_data,
  input  logic                    s1_en,
  input  logic [`ST_ADDR_W-1:0]   s1_addr,
  input  st_pkg::st_size_e        s1_size,
  input  logic [`ST_DATA_W-1:0]   s1_data,
  output logic                    busy,
  output logic                    w0_en,
  output logic [`ST_ADDR_W-1:0]   w0_addr,
  output logic [`ST_BANK_W-1:0]   w0_bank,
  output logic [`ST_BANK_W-1:0]   w0_end_bank,
  output logic [`ST_BEN_W-1:0]    w0_bgn_ben,
  output logic [`ST_BEN_W-1:0]    w0_end_ben,
  output logic [`ST_WDATA_W-1:0]  w0_data,
  output logic                    w1_en,
  output logic [`ST_ADDR_W-1:0]   w1_addr,
  output logic [`ST_BANK_W-1:0]   w1_bank,
  output logic [`ST_BANK_W-1:0]   w1_end_bank,
  output logic [`ST_BEN_W-1:0]    w1_bgn_ben,
  output logic [`ST_BEN_W-1:0]    w1_end_ben,
  output logic [`ST_WDATA_W-1:0]  w1_data
);

  // bank map results per slot
  logic [`ST_BANK_W-1:0] m0_bgn_bank, m0_end_bank, m1_bgn_bank, m1_end_bank;
  logic [`ST_BEN_W-1:0]  m0_bgn_ben, m0_end_ben, m1_bgn_ben, m1_end_ben;
  logic [`ST_BANKS-1:0]  m0_mask, m1_mask;

  // issue side toward the write ports
  logic                  i0_en, i1_en;
  logic [`ST_ADDR_W-1:0] i0_addr, i1_addr;
  logic [`ST_DATA_W-1:0] i0_data, i1_data;
  logic [`ST_BANK_W-1:0] i0_bgn_bank, i0_end_bank, i1_bgn_bank, i1_end_bank;
  logic [`ST_BEN_W-1:0]  i0_bgn_ben, i0_end_ben, i1_bgn_ben, i1_end_ben;

  st_bank_map u_map0 (
    .addr(s0_addr), .size(s0_size), .en(s0_en),
    .bgn_bank(m0_bgn_bank), .end_bank(m0_end_bank),
    .bgn_ben(m0_bgn_ben), .end_ben(m0_end_ben), .bank_mask(m0_mask)
  );

  st_bank_map u_map1 (
    .addr(s1_addr), .size(s1_size), .en(s1_en),
    .bgn_bank(m1_bgn_bank), .end_bank(m1_end_bank),
    .bgn_ben(m1_bgn_ben), .end_ben(m1_end_ben), .bank_mask(m1_mask)
  );

  st_pair_order u_order (
    .clk(clk), .rst(rst), .hold(hold),
    .s0_en(s0_en), .s0_addr(s0_addr), .s0_data(s0_data),
    .s0_bgn_bank(m0_bgn_bank), .s0_end_bank(m0_end_bank),
    .s0_bgn_ben(m0_bgn_ben), .s0_end_ben(m0_end_ben), .s0_mask(m0_mask),
    .s1_en(s1_en), .s1_addr(s1_addr), .s1_data(s1_data),
    .s1_bgn_bank(m1_bgn_bank), .s1_end_bank(m1_end_bank),
    .s1_bgn_ben(m1_bgn_ben), .s1_end_ben(m1_end_ben), .s1_mask(m1_mask),
    .busy(busy), .i0_en(i0_en), .i1_en(i1_en),
    .i0_addr(i0_addr), .i0_data(i0_data),
    .i0_bgn_bank(i0_bgn_bank), .i0_end_bank(i0_end_bank),
    .i0_bgn_ben(i0_bgn_ben), .i0_end_ben(i0_end_ben),
    .i1_addr(i1_addr), .i1_data(i1_data),
    .i1_bgn_bank(i1_bgn_bank), .i1_end_bank(i1_end_bank),
    .i1_bgn_ben(i1_bgn_ben), .i1_end_ben(i1_end_ben)
  );

  st_wport u_wport (
    .clk(clk), .rst(rst), .hold(hold),
    .i0_en(i0_en), .i1_en(i1_en),
    .i0_addr(i0_addr), .i0_data(i0_data),
    .i0_bgn_bank(i0_bgn_bank), .i0_end_bank(i0_end_bank),
    .i0_bgn_ben(i0_bgn_ben), .i0_end_ben(i0_end_ben),
    .i1_addr(i1_addr), .i1_data(i1_data),
    .i1_bgn_bank(i1_bgn_bank), .i1_end_bank(i1_end_bank),
    .i1_bgn_ben(i1_bgn_ben), .i1_end_ben(i1_end_ben),
    .w0_en(w0_en), .w0_addr(w0_addr), .w0_bank(w0_bank), .w0_end_bank(w0_end_bank),
    .w0_bgn_ben(w0_bgn_ben), .w0_end_ben(w0_end_ben), .w0_data(w0_data),
    .w1_en(w1_en), .w1_addr(w1_addr), .w1_bank(w1_bank), .w1_end_bank(w1_end_bank),
    .w1_bgn_ben(w1_bgn_ben), .w1_end_ben(w1_end_ben), .w1_data(w1_data)
  );

endmodule

`default_nettype wire

// File: hw/st_wport.sv
`default_nettype none
`timescale 1ns/1ps
`include "st_config.svh"

module st_wport (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    hold,
  input  logic                    i0_en,
  input  logic                    i1_en,
  input  logic [`ST_ADDR_W-1:0]   i0_addr,
  input  logic [`ST_DATA_W-1:0]   i0_data,
  input  logic [`ST_BANK_W-1:0]   i0_bgn_bank,
  input  logic [`ST_BANK_W-1:0]   i0_end_bank,
  input  logic [`ST_BEN_W-1:0]    i0_bgn_ben,
  input  logic [`ST_BEN_W-1:0]    i0_end_ben,
  input  logic [`ST_ADDR_W-1:0]   i1_addr,
  input  logic [`ST_DATA_W-1:0]   i1_data,
  input  logic [`ST_BANK_W-1:0]   i1_bgn_bank,
  input  logic [`ST_BANK_W-1:0]   i1_end_bank,
  input  logic [`ST_BEN_W-1:0]    i1_bgn_ben,
  input  logic [`ST_BEN_W-1:0]    i1_end_ben,
  output logic                    w0_en,
  output logic [`ST_ADDR_W-1:0]   w0_addr,
  output logic [`ST_BANK_W-1:0]   w0_bank,
  output logic [`ST_BANK_W-1:0]   w0_end_bank,
  output logic [`ST_BEN_W-1:0]    w0_bgn_ben,
  output logic [`ST_BEN_W-1:0]    w0_end_ben,
  output logic [`ST_WDATA_W-1:0]  w0_data,
  output logic                    w1_en,
  output logic [`ST_ADDR_W-1:0]   w1_addr,
  output logic [`ST_BANK_W-1:0]   w1_bank,
  output logic [`ST_BANK_W-1:0]   w1_end_bank,
  output logic [`ST_BEN_W-1:0]    w1_bgn_ben,
  output logic [`ST_BEN_W-1:0]    w1_end_ben,
  output logic [`ST_WDATA_W-1:0]  w1_data
);

  // place data at its byte offset in the three bank window
  function automatic logic [`ST_WDATA_W-1:0] align(
    input logic [`ST_DATA_W-1:0] data,
    input logic [`ST_OFF_W-1:0]  off
  );
    logic [`ST_WDATA_W-1:0] wide;
    wide = {{(`ST_WDATA_W - `ST_DATA_W){1'b0}}, data};
    return wide << {off, 3'b000};
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      w0_en <= 1'b0;
      w1_en <= 1'b0;
    end else begin
      w0_en <= i0_en && !hold;
      w1_en <= i1_en && !hold;
    end
  end

  always_ff @(posedge clk) begin
    if (i0_en && !hold) begin
      w0_addr     <= i0_addr;
      w0_bank     <= i0_bgn_bank;
      w0_end_bank <= i0_end_bank;
      w0_bgn_ben  <= i0_bgn_ben;
      w0_end_ben  <= i0_end_ben;
      w0_data     <= align(i0_data, i0_addr[`ST_OFF_W-1:0]);
    end
    if (i1_en && !hold) begin
      w1_addr     <= i1_addr;
      w1_bank     <= i1_bgn_bank;
      w1_end_bank <= i1_end_bank;
      w1_bgn_ben  <= i1_bgn_ben;
      w1_end_ben  <= i1_end_ben;
      w1_data     <= align(i1_data, i1_addr[`ST_OFF_W-1:0]);
    end
  end

  a_idle_after_rst: assert property (
    @(posedge clk) rst |=> (!w0_en && !w1_en)
  );

endmodule

`default_nettype wire

// File: hw/st_pair_order.sv
`default_nettype none
`timescale 1ns/1ps
`include "st_config.svh"

module st_pair_order (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   hold,
  input  logic                   s0_en,
  input  logic [`ST_ADDR_W-1:0]  s0_addr,
  input  logic [`ST_DATA_W-1:0]  s0_data,
  input  logic [`ST_BANK_W-1:0]  s0_bgn_bank,
  input  logic [`ST_BANK_W-1:0]  s0_end_bank,
  input  logic [`ST_BEN_W-1:0]   s0_bgn_ben,
  input  logic [`ST_BEN_W-1:0]   s0_end_ben,
  input  logic [`ST_BANKS-1:0]   s0_mask,
  input  logic                   s1_en,
  input  logic [`ST_ADDR_W-1:0]  s1_addr,
  input  logic [`ST_DATA_W-1:0]  s1_data,
  input  logic [`ST_BANK_W-1:0]  s1_bgn_bank,
  input  logic [`ST_BANK_W-1:0]  s1_end_bank,
  input  logic [`ST_BEN_W-1:0]   s1_bgn_ben,
  input  logic [`ST_BEN_W-1:0]   s1_end_ben,
  input  logic [`ST_BANKS-1:0]   s1_mask,
  output logic                   busy,
  output logic                   i0_en,
  output logic                   i1_en,
  output logic [`ST_ADDR_W-1:0]  i0_addr,
  output logic [`ST_DATA_W-1:0]  i0_data,
  output logic [`ST_BANK_W-1:0]  i0_bgn_bank,
  output logic [`ST_BANK_W-1:0]  i0_end_bank,
  output logic [`ST_BEN_W-1:0]   i0_bgn_ben,
  output logic [`ST_BEN_W-1:0]   i0_end_ben,
  output logic [`ST_ADDR_W-1:0]  i1_addr,
  output logic [`ST_DATA_W-1:0]  i1_data,
  output logic [`ST_BANK_W-1:0]  i1_bgn_bank,
  output logic [`ST_BANK_W-1:0]  i1_end_bank,
  output logic [`ST_BEN_W-1:0]   i1_bgn_ben,
  output logic [`ST_BEN_W-1:0]   i1_end_ben
);

  // byte position within the line
  localparam int pos_w = `ST_BANK_W + `ST_OFF_W;

  st_pkg::order_state_e state;

  logic accept;
  logic conflict;

  logic [`ST_ADDR_W-1:0] d_addr;
  logic [`ST_DATA_W-1:0] d_data;
  logic [`ST_BANK_W-1:0] d_bgn_bank;
  logic [`ST_BANK_W-1:0] d_end_bank;
  logic [`ST_BEN_W-1:0]  d_bgn_ben;
  logic [`ST_BEN_W-1:0]  d_end_ben;

  logic [pos_w-1:0] i0_first;
  logic [pos_w-1:0] i1_first;
  logic [pos_w-1:0] i0_len;
  logic [pos_w-1:0] i1_len;

  // highest written byte of the end bank
  function automatic logic [`ST_OFF_W-1:0] top_byte(input logic [`ST_BEN_W-1:0] ben);
    logic [`ST_OFF_W-1:0] t;
    t = '0;
    for (int j = 0; j < `ST_BEN_W; j++) begin
      if (ben[j]) t = `ST_OFF_W'(j);
    end
    return t;
  endfunction

  assign busy   = hold || (state == st_pkg::ORD_DEFER);
  assign accept = !busy;

  // byte overlap checked per bank that both stores touch
  always_comb begin
    logic [`ST_BEN_W-1:0] ben0;
    logic [`ST_BEN_W-1:0] ben1;
    conflict = 1'b0;
    for (int b = 0; b < `ST_BANKS; b++) begin
      ben0 = '1;
      ben1 = '1;
      if (s0_bgn_bank == `ST_BANK_W'(b)) ben0 = s0_bgn_ben;
      else if (s0_end_bank == `ST_BANK_W'(b)) ben0 = s0_end_ben;
      if (s1_bgn_bank == `ST_BANK_W'(b)) ben1 = s1_bgn_ben;
      else if (s1_end_bank == `ST_BANK_W'(b)) ben1 = s1_end_ben;
      if (s0_mask[b] && s1_mask[b] && ((ben0 & ben1) != '0)) begin
        conflict = s0_en && s1_en;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_pkg::ORD_IDLE;
    end else begin
      case (state)
        st_pkg::ORD_IDLE:  if (accept && conflict) state <= st_pkg::ORD_DEFER;
        st_pkg::ORD_DEFER: if (!hold) state <= st_pkg::ORD_IDLE;
        default:           state <= st_pkg::ORD_IDLE;
      endcase
    end
  end

  // younger store parked until port 1 is free
  always_ff @(posedge clk) begin
    if (accept && conflict) begin
      d_addr     <= s1_addr;
      d_data     <= s1_data;
      d_bgn_bank <= s1_bgn_bank;
      d_end_bank <= s1_end_bank;
      d_bgn_ben  <= s1_bgn_ben;
      d_end_ben  <= s1_end_ben;
    end
  end

  assign i0_en       = accept && s0_en;
  assign i0_addr     = s0_addr;
  assign i0_data     = s0_data;
  assign i0_bgn_bank = s0_bgn_bank;
  assign i0_end_bank = s0_end_bank;
  assign i0_bgn_ben  = s0_bgn_ben;
  assign i0_end_ben  = s0_end_ben;

  always_comb begin
    if (state == st_pkg::ORD_DEFER) begin
      i1_en       = !hold;
      i1_addr     = d_addr;
      i1_data     = d_data;
      i1_bgn_bank = d_bgn_bank;
      i1_end_bank = d_end_bank;
      i1_bgn_ben  = d_bgn_ben;
      i1_end_ben  = d_end_ben;
    end else begin
      i1_en       = accept && s1_en && !conflict;
      i1_addr     = s1_addr;
      i1_data     = s1_data;
      i1_bgn_bank = s1_bgn_bank;
      i1_end_bank = s1_end_bank;
      i1_bgn_ben  = s1_bgn_ben;
      i1_end_ben  = s1_end_ben;
    end
  end

  // issued stores as byte arcs on the line ring
  assign i0_first = {i0_bgn_bank, i0_addr[`ST_OFF_W-1:0]};
  assign i1_first = {i1_bgn_bank, i1_addr[`ST_OFF_W-1:0]};
  assign i0_len   = {i0_end_bank, top_byte(i0_end_ben)} - i0_first;
  assign i1_len   = {i1_end_bank, top_byte(i1_end_ben)} - i1_first;

  // overlapping pair never issues in the same cycle
  // arcs share a byte when either start lies inside the other arc
  a_no_dual_conflict: assert property (
    @(posedge clk) disable iff (rst)
    (i0_en && i1_en) |->
      ((i1_first - i0_first) > i0_len) && ((i0_first - i1_first) > i1_len)
  );

endmodule

`default_nettype wire

// File: hw/st_bank_map.sv
`default_nettype none
`timescale 1ns/1ps
`include "st_config.svh"

module st_bank_map (
  input  logic [`ST_ADDR_W-1:0]  addr,
  input  st_pkg::st_size_e       size,
  input  logic                   en,
  output logic [`ST_BANK_W-1:0]  bgn_bank,
  output logic [`ST_BANK_W-1:0]  end_bank,
  output logic [`ST_BEN_W-1:0]   bgn_ben,
  output logic [`ST_BEN_W-1:0]   end_ben,
  output logic [`ST_BANKS-1:0]   bank_mask
);

  // last byte position relative to the begin bank base, 0..10
  localparam int rel_w = `ST_OFF_W + 2;
  // most banks a single store can touch
  localparam int span_max = `ST_WDATA_W / (8 * `ST_BEN_W);

  logic [`ST_OFF_W-1:0] off;
  logic [rel_w-1:0]     nbytes;
  logic [rel_w-1:0]     last_rel;
  logic [1:0]           span;
  logic [`ST_BEN_W-1:0] tail_ben;

  assign off      = addr[`ST_OFF_W-1:0];
  assign nbytes   = st_pkg::size_bytes(size);
  assign last_rel = {2'b00, off} + nbytes - rel_w'(1);

  // number of bank crossings
  assign span     = last_rel[rel_w-1:`ST_OFF_W];

  assign bgn_bank = addr[`ST_OFF_W +: `ST_BANK_W];
  // wraps past bank 31 back to bank 0
  assign end_bank = bgn_bank + `ST_BANK_W'(span);

  always_comb begin
    for (int i = 0; i < `ST_BEN_W; i++) begin
      bgn_ben[i]  = (rel_w'(i) >= {2'b00, off}) && (rel_w'(i) <= last_rel);
      tail_ben[i] = (`ST_OFF_W'(i) <= last_rel[`ST_OFF_W-1:0]);
    end
  end

  // single bank store, both enables are the same
  assign end_ben = (span == 2'd0) ? bgn_ben : tail_ben;

  // banks touched, begin through end inclusive
  always_comb begin
    logic [`ST_BANK_W-1:0] idx;
    bank_mask = '0;
    for (int k = 0; k < span_max; k++) begin
      idx = bgn_bank + `ST_BANK_W'(k);
      if (en && (2'(k) <= span)) begin
        bank_mask[idx] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/st_pkg.sv
`default_nettype none

package st_pkg;

  // store size opcode, bytes = 1 << code
  typedef enum logic [1:0] {
    SZ_BYTE  = 2'd0,
    SZ_HALF  = 2'd1,
    SZ_WORD  = 2'd2,
    SZ_DWORD = 2'd3
  } st_size_e;

  // slot 1 held back after an overlap with slot 0
  typedef enum logic {
    ORD_IDLE  = 1'b0,
    ORD_DEFER = 1'b1
  } order_state_e;

  // number of bytes written by a store of this size
  function automatic logic [3:0] size_bytes(input st_size_e size);
    logic [3:0] n;
    unique case (size)
      SZ_BYTE:  n = 4'd1;
      SZ_HALF:  n = 4'd2;
      SZ_WORD:  n = 4'd4;
      SZ_DWORD: n = 4'd8;
      default:  n = 4'd1;
    endcase
    return n;
  endfunction

endpackage

`default_nettype wire

// File: hw/st_config.svh
`ifndef ST_CONFIG_SVH
`define ST_CONFIG_SVH

// store request address and payload
`define ST_ADDR_W 16
`define ST_DATA_W 64

// cache line banking
`define ST_BANKS 32
`define ST_BANK_W 5
`define ST_BEN_W 4

// byte offset inside a bank, address bits 1..0
`define ST_OFF_W 2

// aligned write window, three banks wide
`define ST_WDATA_W 96

`endif
